/* design/rob_pkg.sv */
package rob_pkg;

    // Destination register number width
    localparam int REG_W = 5;

    // Operation codes carried from dispatch to the units
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,                      // ALU add wrapping on overflow
        OP_SUB = 3'd1,                      // ALU subtract wrapping below zero
        OP_AND = 3'd2,                      // ALU bitwise and
        OP_XOR = 3'd3,                      // ALU bitwise xor
        OP_MUL = 3'd4,                      // Multiplier low half of product
        OP_DIV = 3'd5                       // Divider unsigned quotient
    } op_e;

    // Reorder buffer entry life cycle
    typedef enum logic [1:0] {
        ENT_FREE = 2'd0,                    // Slot empty
        ENT_WAIT = 2'd1,                    // Divide parked until a divider credit frees
        ENT_EXEC = 2'd2,                    // Sent to a unit
        ENT_DONE = 2'd3                     // Result captured, ready to retire
    } ent_e;

endpackage

/* design/alu_unit.sv */
module alu_unit #(
    parameter int DATA_W    = 16,
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         alu_valid,
    input  rob_pkg::op_e                 alu_op,
    input  logic [DATA_W-1:0]            alu_a,
    input  logic [DATA_W-1:0]            alu_b,
    input  logic [$clog2(ROB_DEPTH)-1:0] alu_tag,
    output logic                         alu_done,
    output logic [$clog2(ROB_DEPTH)-1:0] alu_res_tag,
    output logic [DATA_W-1:0]            alu_res
);

    logic [DATA_W-1:0] res_nxt;             // Combinational result

    always_comb begin
        case (alu_op)
            rob_pkg::OP_SUB: res_nxt = alu_a - alu_b;   // Wraps below zero
            rob_pkg::OP_AND: res_nxt = alu_a & alu_b;
            rob_pkg::OP_XOR: res_nxt = alu_a ^ alu_b;
            default:         res_nxt = alu_a + alu_b;   // Add wrapping on carry out
        endcase
    end

    // Done flag follows valid by one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            alu_done <= 1'b0;
        end else begin
            alu_done <= alu_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_valid) begin
            alu_res     <= res_nxt;         // Result and tag move together
            alu_res_tag <= alu_tag;
        end
    end

endmodule

/* design/mul_unit.sv */
module mul_unit #(
    parameter int DATA_W    = 16,
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         mul_valid,
    input  logic [DATA_W-1:0]            mul_a,
    input  logic [DATA_W-1:0]            mul_b,
    input  logic [$clog2(ROB_DEPTH)-1:0] mul_tag,
    output logic                         mul_done,
    output logic [$clog2(ROB_DEPTH)-1:0] mul_res_tag,
    output logic [DATA_W-1:0]            mul_res
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    logic              s1_valid;            // Operand stage
    logic [TAG_W-1:0]  s1_tag;
    logic [DATA_W-1:0] s1_a;
    logic [DATA_W-1:0] s1_b;
    logic              s2_valid;            // Product stage
    logic [TAG_W-1:0]  s2_tag;
    logic [DATA_W-1:0] s2_prod;             // Low half only

    // Valid bits walk through the three stages
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            mul_done <= 1'b0;
        end else begin
            s1_valid <= mul_valid;
            s2_valid <= s1_valid;
            mul_done <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_a        <= mul_a;               // Stage 1 captures operands
        s1_b        <= mul_b;
        s1_tag      <= mul_tag;
        s2_prod     <= s1_a * s1_b;         // Truncated to DATA_W bits
        s2_tag      <= s1_tag;
        mul_res     <= s2_prod;             // Stage 3 output register
        mul_res_tag <= s2_tag;
    end

endmodule

/* design/div_unit.sv */
module div_unit #(
    parameter int DATA_W    = 16,
    parameter int ROB_DEPTH = 8,
    parameter int DIV_QD    = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         div_valid,
    input  logic [DATA_W-1:0]            div_a,
    input  logic [DATA_W-1:0]            div_b,
    input  logic [$clog2(ROB_DEPTH)-1:0] div_tag,
    output logic                         div_done,
    output logic [$clog2(ROB_DEPTH)-1:0] div_res_tag,
    output logic [DATA_W-1:0]            div_res,
    output logic                         div_credit
);

    localparam int TAG_W = $clog2(ROB_DEPTH);
    localparam int QP_W  = (DIV_QD > 1) ? $clog2(DIV_QD) : 1;
    localparam int QC_W  = $clog2(DIV_QD + 1);
    localparam int BC_W  = $clog2(DATA_W);

    typedef enum logic [1:0] {D_IDLE, D_RUN, D_DONE} dstate_e;

    dstate_e           state;
    logic [DATA_W-1:0] q_a   [DIV_QD];      // Queued dividends
    logic [DATA_W-1:0] q_b   [DIV_QD];      // Queued divisors
    logic [TAG_W-1:0]  q_tag [DIV_QD];
    logic [QP_W-1:0]   wr_ptr;
    logic [QP_W-1:0]   rd_ptr;
    logic [QC_W-1:0]   q_cnt;
    logic              pop;
    logic [DATA_W-1:0] quot;                // Dividend shifts out as quotient shifts in
    logic [DATA_W-1:0] rem;
    logic [DATA_W-1:0] dvsr;
    logic [TAG_W-1:0]  cur_tag;
    logic [BC_W-1:0]   bit_cnt;
    logic [DATA_W:0]   rem_sh;              // Partial remainder with next dividend bit
    logic              rem_ge;
    logic [DATA_W-1:0] rem_diff;

    // Circular pointer step for any queue depth
    function automatic logic [QP_W-1:0] q_next(input logic [QP_W-1:0] p);
        return (p == QP_W'(DIV_QD - 1)) ? '0 : p + 1'b1;
    endfunction

    assign pop        = (state == D_IDLE) && (q_cnt != '0);
    assign div_credit = pop;                // Slot freed as the entry leaves

    assign rem_sh   = {rem, quot[DATA_W-1]};
    assign rem_ge   = rem_sh >= {1'b0, dvsr};   // Zero divisor always passes
    assign rem_diff = rem_sh[DATA_W-1:0] - dvsr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_cnt  <= '0;
            state  <= D_IDLE;
        end else begin
            if (div_valid) wr_ptr <= q_next(wr_ptr);
            if (pop) rd_ptr <= q_next(rd_ptr);
            case ({div_valid, pop})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;    // Push and pop cancel
            endcase
            case (state)
                D_IDLE:  if (pop) state <= D_RUN;
                D_RUN:   if (bit_cnt == BC_W'(DATA_W - 1)) state <= D_DONE;
                default: state <= D_IDLE;   // Result shown for one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (div_valid) begin
            q_a[wr_ptr]   <= div_a;
            q_b[wr_ptr]   <= div_b;
            q_tag[wr_ptr] <= div_tag;
        end
        if (pop) begin
            quot    <= q_a[rd_ptr];         // Load head of queue
            dvsr    <= q_b[rd_ptr];
            cur_tag <= q_tag[rd_ptr];
            rem     <= '0;
            bit_cnt <= '0;
        end else if (state == D_RUN) begin
            rem     <= rem_ge ? rem_diff : rem_sh[DATA_W-1:0];  // Restore on fail
            quot    <= {quot[DATA_W-2:0], rem_ge};
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    assign div_done    = (state == D_DONE);
    assign div_res     = quot;
    assign div_res_tag = cur_tag;

endmodule

/* design/rob_ctrl.sv */
module rob_ctrl #(
    parameter int DATA_W    = 16,
    parameter int ROB_DEPTH = 8,
    parameter int DIV_QD    = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         disp_valid,
    input  rob_pkg::op_e                 disp_op,
    input  logic [DATA_W-1:0]            disp_a,
    input  logic [DATA_W-1:0]            disp_b,
    input  logic [rob_pkg::REG_W-1:0]    disp_dest,
    output logic                         disp_credit,
    output logic                         ret_valid,
    output logic [$clog2(ROB_DEPTH)-1:0] ret_tag,
    output logic [rob_pkg::REG_W-1:0]    ret_dest,
    output logic [DATA_W-1:0]            ret_value,
    output logic                         alu_valid,
    output rob_pkg::op_e                 alu_op,
    output logic [DATA_W-1:0]            alu_a,
    output logic [DATA_W-1:0]            alu_b,
    output logic [$clog2(ROB_DEPTH)-1:0] alu_tag,
    input  logic                         alu_done,
    input  logic [$clog2(ROB_DEPTH)-1:0] alu_res_tag,
    input  logic [DATA_W-1:0]            alu_res,
    output logic                         mul_valid,
    output logic [DATA_W-1:0]            mul_a,
    output logic [DATA_W-1:0]            mul_b,
    output logic [$clog2(ROB_DEPTH)-1:0] mul_tag,
    input  logic                         mul_done,
    input  logic [$clog2(ROB_DEPTH)-1:0] mul_res_tag,
    input  logic [DATA_W-1:0]            mul_res,
    output logic                         div_valid,
    output logic [DATA_W-1:0]            div_a,
    output logic [DATA_W-1:0]            div_b,
    output logic [$clog2(ROB_DEPTH)-1:0] div_tag,
    input  logic                         div_done,
    input  logic [$clog2(ROB_DEPTH)-1:0] div_res_tag,
    input  logic [DATA_W-1:0]            div_res,
    input  logic                         div_credit
);

    localparam int TAG_W = $clog2(ROB_DEPTH);
    localparam int CNT_W = $clog2(DIV_QD + 1);

    rob_pkg::ent_e              ent_state [ROB_DEPTH];
    logic [rob_pkg::REG_W-1:0]  ent_dest  [ROB_DEPTH];
    logic [DATA_W-1:0]          ent_res   [ROB_DEPTH];
    logic [DATA_W-1:0]          ent_a     [ROB_DEPTH];  // Divide operands only
    logic [DATA_W-1:0]          ent_b     [ROB_DEPTH];
    logic [TAG_W-1:0]           head;                   // Oldest entry
    logic [TAG_W-1:0]           tail;                   // Next free slot
    logic [CNT_W-1:0]           div_cred;               // Free divider queue slots
    logic                       is_alu;
    logic                       is_div;
    logic                       div_direct;             // New divide goes straight out
    logic                       div_from_wait;          // Parked divide goes out
    logic                       wait_found;
    logic [TAG_W-1:0]           wait_idx;
    logic                       retire;

    assign is_alu = disp_valid && (disp_op inside {rob_pkg::OP_ADD, rob_pkg::OP_SUB,
                                                   rob_pkg::OP_AND, rob_pkg::OP_XOR});
    assign is_div        = disp_valid && (disp_op == rob_pkg::OP_DIV);
    assign div_direct    = is_div && (div_cred != '0);
    assign div_from_wait = !is_div && wait_found && (div_cred != '0);
    assign retire        = (ent_state[head] == rob_pkg::ENT_DONE);

    // ALU and multiplier take operands straight from dispatch
    assign alu_valid = is_alu;
    assign alu_op    = disp_op;
    assign alu_a     = disp_a;
    assign alu_b     = disp_b;
    assign alu_tag   = tail;
    assign mul_valid = disp_valid && (disp_op == rob_pkg::OP_MUL);
    assign mul_a     = disp_a;
    assign mul_b     = disp_b;
    assign mul_tag   = tail;

    // Divider port muxes new divide against oldest parked one
    assign div_valid = div_direct || div_from_wait;
    assign div_a     = div_direct ? disp_a : ent_a[wait_idx];
    assign div_b     = div_direct ? disp_b : ent_b[wait_idx];
    assign div_tag   = div_direct ? tail : wait_idx;

    // Scan from head so the first hit is the oldest
    always_comb begin
        logic [TAG_W-1:0] idx;
        wait_found = 1'b0;
        wait_idx   = head;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            idx = head + TAG_W'(i);         // Wraps with the pointer width
            if (!wait_found && ent_state[idx] == rob_pkg::ENT_WAIT) begin
                wait_found = 1'b1;
                wait_idx   = idx;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head        <= '0;
            tail        <= '0;
            div_cred    <= CNT_W'(DIV_QD);
            ret_valid   <= 1'b0;
            disp_credit <= 1'b0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                ent_state[i] <= rob_pkg::ENT_FREE;
            end
        end else begin
            ret_valid   <= retire;          // Retire pulse doubles as credit
            disp_credit <= retire;
            if (disp_valid) begin
                ent_state[tail] <= (is_div && !div_direct) ? rob_pkg::ENT_WAIT
                                                           : rob_pkg::ENT_EXEC;
                tail <= tail + 1'b1;
            end
            if (div_from_wait) ent_state[wait_idx] <= rob_pkg::ENT_EXEC;
            // All three result ports may land together
            if (alu_done) ent_state[alu_res_tag] <= rob_pkg::ENT_DONE;
            if (mul_done) ent_state[mul_res_tag] <= rob_pkg::ENT_DONE;
            if (div_done) ent_state[div_res_tag] <= rob_pkg::ENT_DONE;
            if (retire) begin
                ent_state[head] <= rob_pkg::ENT_FREE;
                head            <= head + 1'b1;
            end
            case ({div_valid, div_credit})
                2'b10:   div_cred <= div_cred - 1'b1;
                2'b01:   div_cred <= div_cred + 1'b1;
                default: div_cred <= div_cred;  // Issue and return cancel
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (disp_valid) begin
            ent_dest[tail] <= disp_dest;
            if (is_div) begin
                ent_a[tail] <= disp_a;      // Kept in case no credit
                ent_b[tail] <= disp_b;
            end
        end
        if (alu_done) ent_res[alu_res_tag] <= alu_res;
        if (mul_done) ent_res[mul_res_tag] <= mul_res;
        if (div_done) ent_res[div_res_tag] <= div_res;
        if (retire) begin
            ret_tag   <= head;
            ret_dest  <= ent_dest[head];
            ret_value <= ent_res[head];
        end
    end

endmodule

/* design/rob_core_top.sv */
module rob_core_top #(
    parameter int DATA_W    = 16,
    parameter int ROB_DEPTH = 8,
    parameter int DIV_QD    = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         disp_valid,
    input  rob_pkg::op_e                 disp_op,
    input  logic [DATA_W-1:0]            disp_a,
    input  logic [DATA_W-1:0]            disp_b,
    input  logic [rob_pkg::REG_W-1:0]    disp_dest,
    output logic                         disp_credit,
    output logic                         ret_valid,
    output logic [$clog2(ROB_DEPTH)-1:0] ret_tag,
    output logic [rob_pkg::REG_W-1:0]    ret_dest,
    output logic [DATA_W-1:0]            ret_value
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    logic              alu_valid;           // ALU issue and result
    rob_pkg::op_e      alu_op;
    logic [DATA_W-1:0] alu_a;
    logic [DATA_W-1:0] alu_b;
    logic [TAG_W-1:0]  alu_tag;
    logic              alu_done;
    logic [TAG_W-1:0]  alu_res_tag;
    logic [DATA_W-1:0] alu_res;
    logic              mul_valid;           // Multiplier issue and result
    logic [DATA_W-1:0] mul_a;
    logic [DATA_W-1:0] mul_b;
    logic [TAG_W-1:0]  mul_tag;
    logic              mul_done;
    logic [TAG_W-1:0]  mul_res_tag;
    logic [DATA_W-1:0] mul_res;
    logic              div_valid;           // Divider issue, result and credit
    logic [DATA_W-1:0] div_a;
    logic [DATA_W-1:0] div_b;
    logic [TAG_W-1:0]  div_tag;
    logic              div_done;
    logic [TAG_W-1:0]  div_res_tag;
    logic [DATA_W-1:0] div_res;
    logic              div_credit;

    rob_ctrl #(.DATA_W(DATA_W), .ROB_DEPTH(ROB_DEPTH), .DIV_QD(DIV_QD)) u_ctrl (.*);

    alu_unit #(.DATA_W(DATA_W), .ROB_DEPTH(ROB_DEPTH)) u_alu (
        .clk, .rst, .alu_valid, .alu_op, .alu_a, .alu_b, .alu_tag,
        .alu_done, .alu_res_tag, .alu_res
    );

    mul_unit #(.DATA_W(DATA_W), .ROB_DEPTH(ROB_DEPTH)) u_mul (
        .clk, .rst, .mul_valid, .mul_a, .mul_b, .mul_tag,
        .mul_done, .mul_res_tag, .mul_res
    );

    div_unit #(.DATA_W(DATA_W), .ROB_DEPTH(ROB_DEPTH), .DIV_QD(DIV_QD)) u_div (
        .clk, .rst, .div_valid, .div_a, .div_b, .div_tag,
        .div_done, .div_res_tag, .div_res, .div_credit
    );

endmodule

/* tb/rob_ctrl_sva.sv */
module rob_ctrl_sva #(
    parameter int DIV_QD = 2
) (
    input logic                        clk,
    input logic                        rst,
    input logic                        ret_valid,
    input logic                        disp_credit,
    input logic                        div_valid,
    input rob_pkg::ent_e               head_state,     // State of the entry at head
    input logic [$clog2(DIV_QD+1)-1:0] div_cred
);
    timeunit 1ns;
    timeprecision 1ps;

    // Registered retire means the head was done one cycle earlier
    ret_after_done: assert property (@(posedge clk) disable iff (rst)
        ret_valid |-> $past(head_state) == rob_pkg::ENT_DONE)
        else $error("ret_valid without a completed head entry");

    cred_bound: assert property (@(posedge clk) disable iff (rst)
        div_cred <= DIV_QD)
        else $error("Divider credit count above queue depth");

    div_needs_cred: assert property (@(posedge clk) disable iff (rst)
        div_valid |-> div_cred != '0)
        else $error("Divide issued with no divider credit");

    ret_is_credit: assert property (@(posedge clk) disable iff (rst)
        ret_valid == disp_credit)
        else $error("ret_valid and disp_credit differ");

endmodule

bind rob_ctrl rob_ctrl_sva #(.DIV_QD(DIV_QD)) u_sva (
    .clk, .rst, .ret_valid, .disp_credit, .div_valid,
    .head_state(ent_state[head]), .div_cred
);

/* tb/rob_core_tb.sv */
module rob_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DATA_W    = 16;
    localparam int ROB_DEPTH = 8;
    localparam int DIV_QD    = 2;
    localparam int TAG_W     = $clog2(ROB_DEPTH);
    localparam int TOTAL_OPS = 229;                         // 5 + 7 + 12 + 5 + 200
    localparam int LIMIT     = TOTAL_OPS * (DATA_W + 4) * DIV_QD + 200;

    logic                      clk;
    logic                      rst;
    logic                      disp_valid;
    rob_pkg::op_e              disp_op;
    logic [DATA_W-1:0]         disp_a;
    logic [DATA_W-1:0]         disp_b;
    logic [rob_pkg::REG_W-1:0] disp_dest;
    logic                      disp_credit;
    logic                      ret_valid;
    logic [TAG_W-1:0]          ret_tag;
    logic [rob_pkg::REG_W-1:0] ret_dest;
    logic [DATA_W-1:0]         ret_value;

    logic [TAG_W-1:0]          exp_tag  [$];               // Expected retire stream, oldest first
    logic [rob_pkg::REG_W-1:0] exp_dest [$];
    logic [DATA_W-1:0]         exp_val  [$];
    int                        credits;                     // Dispatcher's own credit count
    int                        disp_count;
    int                        ret_count;
    int                        errors;
    int                        err_base;                    // Error count when the test began
    int                        tests_run;
    int                        tests_failed;
    int                        cyc;
    int                        last_disp_cyc;
    int                        seed;

    rob_core_top #(.DATA_W(DATA_W), .ROB_DEPTH(ROB_DEPTH), .DIV_QD(DIV_QD)) dut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;                                   // 10 ns period

    // Golden model of every opcode
    function automatic logic [DATA_W-1:0] expected_result(input rob_pkg::op_e op,
                                                          input logic [DATA_W-1:0] a,
                                                          input logic [DATA_W-1:0] b);
        case (op)
            rob_pkg::OP_ADD: return a + b;                  // Wraps in DATA_W bits
            rob_pkg::OP_SUB: return a - b;
            rob_pkg::OP_AND: return a & b;
            rob_pkg::OP_XOR: return a ^ b;
            rob_pkg::OP_MUL: return a * b;                  // Low half only
            default:         return (b == '0) ? '1 : a / b;  // Divide by zero gives all ones
        endcase
    endfunction

    function automatic void compare_field(input string name, input int exp, input int got);
        assert (exp == got) else begin
            $display("FAIL t=%0t %s expected=%0h actual=%0h", $time, name, exp, got);
            errors++;
        end
    endfunction

    // Cycle count and run limit
    always @(posedge clk) begin
        cyc++;
        if (cyc > LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    // Retire checker and credit return sampled mid-cycle
    always @(negedge clk) begin
        if (disp_credit) credits++;
        if (ret_valid) begin
            ret_count++;
            assert (exp_val.size() != 0) else begin
                $display("Retirement at %0t with no operation outstanding", $time);
                errors++;
            end
            if (exp_val.size() != 0) begin
                compare_field("ret_tag", exp_tag.pop_front(), ret_tag);
                compare_field("ret_dest", exp_dest.pop_front(), ret_dest);
                compare_field("ret_value", exp_val.pop_front(), ret_value);
            end
        end
    end

    // Called and returns 1 ns after a rising edge
    task automatic dispatch(input rob_pkg::op_e op, input logic [DATA_W-1:0] a,
                            input logic [DATA_W-1:0] b);
        logic [rob_pkg::REG_W-1:0] dest;
        while (credits == 0) begin                          // Hold off without credits
            @(posedge clk);
            #1;
        end
        dest       = rob_pkg::REG_W'(disp_count * 7 + 1);   // Spread over register numbers
        disp_valid = 1'b1;
        disp_op    = op;
        disp_a     = a;
        disp_b     = b;
        disp_dest  = dest;
        exp_tag.push_back(TAG_W'(disp_count % ROB_DEPTH));
        exp_dest.push_back(dest);
        exp_val.push_back(expected_result(op, a, b));
        credits--;
        disp_count++;
        last_disp_cyc = cyc;
        @(posedge clk);
        #1;
        disp_valid = 1'b0;
    endtask

    // One ALU op in an empty buffer and its latency check
    task automatic alu_lone(input rob_pkg::op_e op, input logic [DATA_W-1:0] a,
                            input logic [DATA_W-1:0] b);
        dispatch(op, a, b);
        do @(negedge clk); while (!ret_valid);
        compare_field("ret_valid latency", 3, cyc - last_disp_cyc);
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name);
        while (ret_count < disp_count) @(posedge clk);      // Drain by retirements seen
        @(posedge clk);
        #1;
        compare_field("credits", ROB_DEPTH, credits);
        compare_field("ret_count", disp_count, ret_count);
        tests_run++;
        if (errors == err_base) begin
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - err_base);
        end
        err_base = errors;
    endtask

    initial begin
        rob_pkg::op_e      op;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        seed       = 46686;
        rst        = 1'b1;
        disp_valid = 1'b0;
        disp_op    = rob_pkg::OP_ADD;
        disp_a     = '0;
        disp_b     = '0;
        disp_dest  = '0;
        credits    = ROB_DEPTH;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        alu_lone(rob_pkg::OP_ADD, 16'hFFF0, 16'h0025);      // Carry out dropped
        alu_lone(rob_pkg::OP_SUB, 16'h0003, 16'h0010);      // Borrow wraps
        alu_lone(rob_pkg::OP_AND, 16'hF0F0, 16'h3C3C);
        alu_lone(rob_pkg::OP_XOR, 16'hAAAA, 16'h5A5A);
        alu_lone(rob_pkg::OP_ADD, 16'h1234, 16'h4321);
        finish_test("single_alu");

        dispatch(rob_pkg::OP_DIV, 16'hEA60, 16'h0003);      // Long op holds the head
        dispatch(rob_pkg::OP_MUL, 16'h0123, 16'h0456);
        dispatch(rob_pkg::OP_ADD, 16'h7FFF, 16'h0001);
        dispatch(rob_pkg::OP_MUL, 16'hFFFF, 16'hFFFF);
        dispatch(rob_pkg::OP_XOR, 16'h0F0F, 16'hFFFF);
        dispatch(rob_pkg::OP_MUL, 16'h0100, 16'h0100);      // Low half all zero
        dispatch(rob_pkg::OP_SUB, 16'h0000, 16'h0001);
        finish_test("mixed_order");

        dispatch(rob_pkg::OP_DIV, 16'hFFFF, 16'h0001);      // Stalls retirement
        for (int i = 0; i < ROB_DEPTH - 1; i++) begin
            dispatch(rob_pkg::OP_ADD, DATA_W'(i * 5), DATA_W'(i * 3));
        end
        compare_field("credits", 0, credits);               // Buffer full
        for (int i = 0; i < 4; i++) begin
            dispatch(rob_pkg::OP_SUB, DATA_W'(i), DATA_W'(100));
        end
        finish_test("credit_limit");

        dispatch(rob_pkg::OP_DIV, 16'd1000, 16'd7);         // More divides than queue slots
        dispatch(rob_pkg::OP_DIV, 16'hFFFF, 16'd3);
        dispatch(rob_pkg::OP_DIV, 16'd1234, 16'd0);
        dispatch(rob_pkg::OP_DIV, 16'd500, 16'd500);
        dispatch(rob_pkg::OP_DIV, 16'd7, 16'd9);
        finish_test("divide_queue");

        for (int i = 0; i < 200; i++) begin
            op = rob_pkg::op_e'(3'($unsigned($random(seed)) % 6));
            a  = DATA_W'($random(seed));
            b  = DATA_W'($random(seed));
            if (op == rob_pkg::OP_DIV) b = b >> ($unsigned($random(seed)) % DATA_W);
            dispatch(op, a, b);
        end
        finish_test("random_mix");
        compare_field("expected queue size", 0, exp_val.size());

        $display("Tests run %0d, failed %0d, errors %0d, retired %0d of %0d",
                 tests_run, tests_failed, errors, ret_count, disp_count);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* all.f */
design/rob_pkg.sv
design/alu_unit.sv
design/mul_unit.sv
design/div_unit.sv
design/rob_ctrl.sv
design/rob_core_top.sv
tb/rob_ctrl_sva.sv
tb/rob_core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the reorder buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module rob_core_tb

out=$(./obj_dir/Vrob_core_tb)
echo "$out"

echo "$out" | grep -q "^Done: no errors$"
